// File: sim.f
colourPkg.sv
yuvPairIf.sv
rgbPairIf.sv
apbRegs.sv
frameSequencer.sv
chromaUpsampler.sv
colourConverter.sv
rgbWriter.sv
colourTop.sv
colourTop_chk.sv
colourTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS = --timing --assert -Wno-fatal
TOP = colourTb
FILELIST = sim.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -o $(TOP) -f $(FILELIST)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: colourTb.sv
// Testbench for colourTop; drives APB starts over a memory model and checks every RGB write
`timescale 1ns/1ps
`default_nettype none

module colourTb;
	import colourPkg::*;

	localparam int ImageWidth = 16;
	localparam int ImageHeight = 4;
	localparam int PixelCount = ImageWidth * ImageHeight;
	localparam int UBase = PixelCount / 2;
	localparam int VBase = UBase + PixelCount / 4;
	localparam int RgbBase = VBase + PixelCount / 4;
	localparam int RgbWords = PixelCount * 3 / 2;
	localparam int MemSize = 1024;
	localparam int PollLimit = 200;

	logic CLOCK_50_I;
	logic resetn;
	logic [3:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic memRdEn;
	addr_t memRdAddr;
	word_t memRdData;
	logic memWrEn;
	addr_t memWrAddr;
	word_t memWrData;

	word_t mem [MemSize];
	word_t rdPipe [2];             // Two cycles of read latency
	int wrAddrLog [$];
	int wrDataLog [$];
	int expAddr [$];
	int expData [$];
	integer seed;

	colourTop #(.ImageWidth(ImageWidth), .ImageHeight(ImageHeight)) dut (.*);

	initial begin
		CLOCK_50_I = 1'b0;
		forever #10 CLOCK_50_I = ~CLOCK_50_I;
	end

	// Requests and writes sampled mid-cycle, read data driven just after the edge
	always @(negedge CLOCK_50_I) begin
		rdPipe[1] = rdPipe[0];
		rdPipe[0] = memRdEn ? mem[int'(memRdAddr) % MemSize] : 16'h0000;
		if (memWrEn) begin
			mem[int'(memWrAddr) % MemSize] = memWrData;
			wrAddrLog.push_back(int'(memWrAddr));
			wrDataLog.push_back(int'(memWrData));
		end
	end

	always @(posedge CLOCK_50_I) begin
		#1;
		memRdData = rdPipe[1];
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input int expected, input int actual);
		assert (expected == actual)
		else failRun($sformatf("Mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual));
	endtask

	// Tasks start and end 1 ns after a rising edge
	task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge CLOCK_50_I);
		#1 penable = 1'b1;
		@(negedge CLOCK_50_I);
		err = pslverr;
		@(posedge CLOCK_50_I);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge CLOCK_50_I);
		#1 penable = 1'b1;
		@(negedge CLOCK_50_I);
		data = prdata;
		err = pslverr;
		@(posedge CLOCK_50_I);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	function automatic int rowOfWord(input int a);
		if (a < UBase)
			return a / (ImageWidth / 2);
		else if (a < VBase)
			return (a - UBase) / (ImageWidth / 4);
		return (a - VBase) / (ImageWidth / 4);
	endfunction

	// Random planes, one row all zero and one all full so the clip limits are reached
	task automatic fillFrame(input int zeroRow, input int fullRow);
		int row;
		word_t w;
		for (int a = 0; a < RgbBase; a++) begin
			row = rowOfWord(a);
			w = 16'($random(seed));
			if (row == zeroRow)
				w = 16'h0000;
			else if (row == fullRow)
				w = 16'hFFFF;
			mem[a] = w;
		end
	endtask

	function automatic int clamp255(input int v);
		if (v < 0)
			return 0;
		if (v > 255)
			return 255;
		return v;
	endfunction

	function automatic int lumaAt(input int row, input int x);
		word_t w;
		w = mem[row * ImageWidth / 2 + x / 2];
		return (x % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);
	endfunction

	function automatic int chromaAt(input int base, input int row, input int j);
		int n;
		word_t w;
		n = j;
		if (n < 0)
			n = 0;
		if (n > ImageWidth / 2 - 1)
			n = ImageWidth / 2 - 1;        // Edge sample repeats
		w = mem[base + row * ImageWidth / 4 + n / 2];
		return (n % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);
	endfunction

	function automatic int interpolate(input int base, input int row, input int j);
		int sum;
		sum = 21 * chromaAt(base, row, j - 2) - 52 * chromaAt(base, row, j - 1)
			+ 159 * chromaAt(base, row, j) + 159 * chromaAt(base, row, j + 1)
			- 52 * chromaAt(base, row, j + 2) + 21 * chromaAt(base, row, j + 3);
		return clamp255((sum + 128) >>> 8);
	endfunction

	task automatic buildExpected();
		int y;
		int u;
		int v;
		int rC [2];
		int gC [2];
		int bC [2];
		int idx;
		expAddr.delete();
		expData.delete();
		for (int row = 0; row < ImageHeight; row++) begin
			for (int k = 0; k < ImageWidth / 2; k++) begin
				for (int p = 0; p < 2; p++) begin
					y = lumaAt(row, 2 * k + p) - 16;
					u = ((p == 0) ? chromaAt(UBase, row, k) : interpolate(UBase, row, k)) - 128;
					v = ((p == 0) ? chromaAt(VBase, row, k) : interpolate(VBase, row, k)) - 128;
					rC[p] = clamp255((76284 * y + 104595 * v) >>> 16);
					gC[p] = clamp255((76284 * y - 25624 * u - 53281 * v) >>> 16);
					bC[p] = clamp255((76284 * y + 132251 * u) >>> 16);
				end
				idx = RgbBase + 3 * (row * ImageWidth / 2 + k);
				expAddr.push_back(idx);
				expData.push_back(rC[0] * 256 + gC[0]);
				expAddr.push_back(idx + 1);
				expData.push_back(bC[0] * 256 + rC[1]);
				expAddr.push_back(idx + 2);
				expData.push_back(gC[1] * 256 + bC[1]);
			end
		end
	endtask

	task automatic checkWrites(input string name);
		checkValue($sformatf("%s write count", name), RgbWords, wrAddrLog.size());
		for (int i = 0; i < RgbWords; i++) begin
			checkValue($sformatf("%s word %0d address", name, i), expAddr[i], wrAddrLog[i]);
			checkValue($sformatf("%s word %0d data", name, i), expData[i], wrDataLog[i]);
		end
	endtask

	task automatic runFrame(input string name, input int zeroRow, input int fullRow);
		logic [31:0] status;
		logic [31:0] rows;
		logic err;
		int polls;
		fillFrame(zeroRow, fullRow);
		buildExpected();
		wrAddrLog.delete();
		wrDataLog.delete();
		apbWrite(RegCtrl, 32'd1, err);
		checkValue($sformatf("%s start pslverr", name), 0, err);
		apbRead(RegStatus, status, err);
		checkValue($sformatf("%s status after start", name), 1, status);
		apbRead(RegRows, rows, err);
		checkValue($sformatf("%s rows after start", name), 0, rows);
		// Second start lands mid-frame, once rows are counted and writes are under way
		polls = 0;
		while (rows == 0) begin
			if (polls == PollLimit) begin
				failRun($sformatf("%s: no row completed, timed out while polling", name));
			end else begin
				apbRead(RegRows, rows, err);
				polls++;
			end
		end
		apbWrite(RegCtrl, 32'd1, err);
		checkValue($sformatf("%s busy start pslverr", name), 0, err);
		status = 32'd0;
		polls = 0;
		while (!status[1]) begin
			if (polls == PollLimit) begin
				failRun($sformatf("%s: done bit was never set, timed out while polling", name));
			end else begin
				apbRead(RegStatus, status, err);
				if (!status[1])
					checkValue($sformatf("%s busy while running", name), 1, status[0]);
				polls++;
			end
		end
		checkValue($sformatf("%s busy after done", name), 0, status[0]);
		apbRead(RegRows, rows, err);
		checkValue($sformatf("%s rows after done", name), ImageHeight, rows);
		repeat (20) @(posedge CLOCK_50_I);
		#1;
		checkWrites(name);
	endtask

	initial begin
		logic [31:0] data;
		logic err;
		seed = 23;
		resetn = 1'b0;
		paddr = 4'h0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 32'd0;
		memRdData = 16'h0000;
		rdPipe[0] = 16'h0000;
		rdPipe[1] = 16'h0000;
		for (int a = 0; a < MemSize; a++)
			mem[a] = 16'(a) ^ 16'hC3A5;
		repeat (2) @(posedge CLOCK_50_I);
		#1 resetn = 1'b1;

		apbRead(RegStatus, data, err);
		checkValue("reset status", 0, data);
		apbRead(RegRows, data, err);
		checkValue("reset rows", 0, data);
		apbRead(4'hC, data, err);
		checkValue("unmapped pslverr", 1, err);

		runFrame("frame1", 1, 3);
		runFrame("frame2", 2, 0);

		if (dut.chk.failCount == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			failRun("A bound assertion on colourTop failed during the run");
		end
	end

endmodule

`default_nettype wire

// File: colourTop_chk.sv
// Concurrent assertions on colourTop internals, attached to every colourTop by bind
`timescale 1ns/1ps
`default_nettype none

module colourTopChk #(
	parameter int RgbBase = 64,
	parameter int RgbWords = 96
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic pready,
	input logic start,
	input logic busy,
	input logic memRdEn,
	input logic memWrEn,
	input colourPkg::addr_t memWrAddr
);

	int failCount = 0;     // Read by the testbench at the end

	wrInRegion: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		memWrEn |-> (memWrAddr >= RgbBase && memWrAddr < RgbBase + RgbWords))
	else begin
		$error("RGB write outside the output region");
		failCount++;
	end

	readyHigh: assert property (@(posedge CLOCK_50_I) disable iff (!resetn) pready)
	else begin
		$error("pready went low");
		failCount++;
	end

	// Start is a single-cycle pulse
	startPulse: assert property (@(posedge CLOCK_50_I) disable iff (!resetn) start |=> !start)
	else begin
		$error("start held for more than one cycle");
		failCount++;
	end

	// No start while a frame is still moving data
	startIdle: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		start |-> !(memRdEn || memWrEn))
	else begin
		$error("start raised while a frame was in flight");
		failCount++;
	end

	busyWindow: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		(memRdEn || memWrEn) |-> busy)
	else begin
		$error("memory traffic outside the busy window");
		failCount++;
	end

endmodule

bind colourTop colourTopChk #(
	.RgbBase(RgbBase),
	.RgbWords(ImageWidth * ImageHeight * 3 / 2)
) chk (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.pready(pready),
	.start(start),
	.busy(busy),
	.memRdEn(memRdEn),
	.memWrEn(memWrEn),
	.memWrAddr(memWrAddr)
);

`default_nettype wire

// File: colourTop.sv
// Top level of the YUV 4:2:2 to RGB core, with APB control and plain memory ports
`timescale 1ns/1ps
`default_nettype none

module colourTop #(
	parameter int ImageWidth = 16,     // Multiple of 4
	parameter int ImageHeight = 4
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic [3:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic memRdEn,
	output colourPkg::addr_t memRdAddr,
	input colourPkg::word_t memRdData,
	output logic memWrEn,
	output colourPkg::addr_t memWrAddr,
	output colourPkg::word_t memWrData
);

	// Y first, then U and V planes, then the RGB output
	localparam int PixelCount = ImageWidth * ImageHeight;
	localparam int UBase = PixelCount / 2;
	localparam int VBase = UBase + PixelCount / 4;
	localparam int RgbBase = VBase + PixelCount / 4;

	logic start;
	logic busy;
	logic rowDone;
	logic frameDone;
	logic uLoad;
	logic vLoad;
	logic shift;

	yuvPairIf yuvBus ();
	rgbPairIf rgbBus ();

	apbRegs regs (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.start(start),
		.frameDone(frameDone),
		.rowDone(rowDone),
		.busy(busy)
	);

	frameSequencer #(
		.ImageWidth(ImageWidth),
		.ImageHeight(ImageHeight),
		.UBase(UBase),
		.VBase(VBase)
	) seq (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.start(start),
		.memRdEn(memRdEn),
		.memRdAddr(memRdAddr),
		.memRdData(memRdData),
		.uLoad(uLoad),
		.vLoad(vLoad),
		.shift(shift),
		.pair(yuvBus.src)
	);

	// Window refills once the last pair of a row has left
	chromaUpsampler uUps (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.load(uLoad),
		.word(memRdData),
		.shift(shift),
		.rowStart(yuvBus.valid & yuvBus.rowLast),
		.outEven(yuvBus.uEven),
		.outOdd(yuvBus.uOdd)
	);

	chromaUpsampler vUps (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.load(vLoad),
		.word(memRdData),
		.shift(shift),
		.rowStart(yuvBus.valid & yuvBus.rowLast),
		.outEven(yuvBus.vEven),
		.outOdd(yuvBus.vOdd)
	);

	colourConverter csc (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.yuv(yuvBus.dst),
		.rgb(rgbBus.src)
	);

	rgbWriter #(
		.RgbBase(RgbBase),
		.ImageHeight(ImageHeight)
	) writer (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.start(start),
		.rgb(rgbBus.dst),
		.memWrEn(memWrEn),
		.memWrAddr(memWrAddr),
		.memWrData(memWrData),
		.rowDone(rowDone),
		.frameDone(frameDone)
	);

endmodule

`default_nettype wire

// File: rgbWriter.sv
// Packs each RGB pixel pair into three memory words and tracks rows to signal frame end
`timescale 1ns/1ps
`default_nettype none

module rgbWriter #(
	parameter int RgbBase = 96,
	parameter int ImageHeight = 4
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic start,
	rgbPairIf.dst rgb,
	output logic memWrEn,
	output colourPkg::addr_t memWrAddr,
	output colourPkg::word_t memWrData,
	output logic rowDone,
	output logic frameDone
);
	import colourPkg::*;

	localparam int RowW = $clog2(ImageHeight + 1);

	sample_t [1:0] rHeld, gHeld, bHeld;
	logic heldLast;
	logic [1:0] phase;             // 1..3 while writing, 0 when idle
	logic [RowW-1:0] rowCnt;

	assign memWrEn = phase != 2'd0;

	always_comb begin
		case (phase)
			2'd1: memWrData = {rHeld[0], gHeld[0]};
			2'd2: memWrData = {bHeld[0], rHeld[1]};
			default: memWrData = {gHeld[1], bHeld[1]};
		endcase
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (rgb.valid) begin
			rHeld <= rgb.r;
			gHeld <= rgb.g;
			bHeld <= rgb.b;
			heldLast <= rgb.rowLast;
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			phase <= 2'd0;
			memWrAddr <= addr_t'(RgbBase);
			rowCnt <= '0;
			rowDone <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			rowDone <= 1'b0;
			frameDone <= 1'b0;
			if (rgb.valid)
				phase <= 2'd1;
			else if (phase != 2'd0)
				phase <= phase + 2'd1;     // Wraps to idle after the third word
			if (memWrEn)
				memWrAddr <= memWrAddr + 1'b1;
			if (phase == 2'd3 && heldLast) begin
				rowDone <= 1'b1;
				if (rowCnt == RowW'(ImageHeight - 1)) begin
					frameDone <= 1'b1;
					rowCnt <= '0;
				end else begin
					rowCnt <= rowCnt + 1'b1;
				end
			end
			if (start) begin
				memWrAddr <= addr_t'(RgbBase);
				rowCnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: colourConverter.sv
// Three-stage YUV to RGB matrix for both pixels of a pair, with clipping
`timescale 1ns/1ps
`default_nettype none

module colourConverter (
	input logic CLOCK_50_I,
	input logic resetn,
	yuvPairIf.dst yuv,
	rgbPairIf.src rgb
);
	import colourPkg::*;

	logic signed [8:0] yOff [2];
	logic signed [8:0] uOff [2];
	logic signed [8:0] vOff [2];
	logic signed [31:0] yProd [2];
	logic signed [31:0] rvProd [2];
	logic signed [31:0] guProd [2];
	logic signed [31:0] gvProd [2];
	logic signed [31:0] buProd [2];
	logic signed [31:0] rSum [2];
	logic signed [31:0] gSum [2];
	logic signed [31:0] bSum [2];
	logic s1Valid, s2Valid;
	logic s1Last, s2Last;

	// Valid and rowLast walk the pipe together
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			rgb.valid <= 1'b0;
			s1Last <= 1'b0;
			s2Last <= 1'b0;
			rgb.rowLast <= 1'b0;
		end else begin
			s1Valid <= yuv.valid;
			s2Valid <= s1Valid;
			rgb.valid <= s2Valid;
			s1Last <= yuv.valid & yuv.rowLast;
			s2Last <= s1Last;
			rgb.rowLast <= s2Last;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		// Stage 1, remove offsets
		yOff[0] <= $signed({1'b0, yuv.y[0]}) - $signed({1'b0, LumaOffset});
		yOff[1] <= $signed({1'b0, yuv.y[1]}) - $signed({1'b0, LumaOffset});
		uOff[0] <= $signed({1'b0, yuv.uEven}) - $signed({1'b0, ChromaOffset});
		uOff[1] <= $signed({1'b0, yuv.uOdd}) - $signed({1'b0, ChromaOffset});
		vOff[0] <= $signed({1'b0, yuv.vEven}) - $signed({1'b0, ChromaOffset});
		vOff[1] <= $signed({1'b0, yuv.vOdd}) - $signed({1'b0, ChromaOffset});

		for (int i = 0; i < 2; i++) begin
			// Stage 2, products
			yProd[i] <= $signed({1'b0, CscY}) * yOff[i];
			rvProd[i] <= $signed({1'b0, CscRv}) * vOff[i];
			guProd[i] <= $signed({1'b0, CscGu}) * uOff[i];
			gvProd[i] <= $signed({1'b0, CscGv}) * vOff[i];
			buProd[i] <= $signed({1'b0, CscBu}) * uOff[i];

			// Stage 3, drop the fraction and saturate
			rgb.r[i] <= clipSample(rSum[i] >>> 16);
			rgb.g[i] <= clipSample(gSum[i] >>> 16);
			rgb.b[i] <= clipSample(bSum[i] >>> 16);
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rSum[i] = yProd[i] + rvProd[i];
			gSum[i] = yProd[i] - guProd[i] - gvProd[i];
			bSum[i] = yProd[i] + buProd[i];
		end
	end

endmodule

`default_nettype wire

// File: chromaUpsampler.sv
// Six-sample chroma window and interpolation filter producing one pair's even and odd samples
`timescale 1ns/1ps
`default_nettype none

module chromaUpsampler (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic load,
	input colourPkg::word_t word,
	input logic shift,
	input logic rowStart,
	output colourPkg::sample_t outEven,
	output colourPkg::sample_t outOdd
);
	import colourPkg::*;

	sample_t win [6];          // c[k-2] .. c[k+3]
	word_t holdWord;           // Next two samples waiting to enter
	logic [1:0] holdCnt;
	logic [1:0] fillCnt;       // Words placed directly into the window
	sample_t nextIn;
	sample_t evenReg;
	logic [17:0] posSum;
	logic [17:0] negSum;
	logic signed [18:0] acc;
	logic signed [31:0] rounded;

	// Nothing left in the row, so the last sample repeats
	always_comb begin
		case (holdCnt)
			2'd2: nextIn = holdWord[15:8];
			2'd1: nextIn = holdWord[7:0];
			default: nextIn = win[5];
		endcase
	end

	assign posSum = 18'(CoefFar) * (18'(win[0]) + 18'(win[5]))
		+ 18'(CoefNear) * (18'(win[2]) + 18'(win[3]));
	assign negSum = 18'(CoefMid) * (18'(win[1]) + 18'(win[4]));

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			fillCnt <= 2'd0;
			holdCnt <= 2'd0;
		end else if (rowStart) begin
			fillCnt <= 2'd0;
			holdCnt <= 2'd0;
		end else begin
			if (load && fillCnt != 2'd2)
				fillCnt <= fillCnt + 2'd1;
			if (load && fillCnt == 2'd2)
				holdCnt <= 2'd2;
			else if (shift && holdCnt != 2'd0)
				holdCnt <= holdCnt - 2'd1;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (load && fillCnt == 2'd0) begin
			// Sample 0 fills the low end, sample 1 stands in for the rest
			win[0] <= word[15:8];
			win[1] <= word[15:8];
			win[2] <= word[15:8];
			win[3] <= word[7:0];
			win[4] <= word[7:0];
			win[5] <= word[7:0];
		end else if (load && fillCnt == 2'd1) begin
			win[4] <= word[15:8];
			win[5] <= word[7:0];
		end else if (load) begin
			holdWord <= word;
		end
		if (shift) begin
			for (int i = 0; i < 5; i++)
				win[i] <= win[i+1];
			win[5] <= nextIn;
			acc <= $signed({1'b0, posSum}) - $signed({1'b0, negSum});
			evenReg <= win[2];
		end
	end

	assign rounded = (acc + 32'sd128) >>> 8;
	assign outEven = evenReg;
	assign outOdd = clipSample(rounded);

endmodule

`default_nettype wire

// File: frameSequencer.sv
// Issues the Y, U and V memory reads of a frame and routes returning words by tag
`timescale 1ns/1ps
`default_nettype none

module frameSequencer #(
	parameter int ImageWidth = 16,
	parameter int ImageHeight = 4,
	parameter int UBase = 32,
	parameter int VBase = 48
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic start,
	output logic memRdEn,
	output colourPkg::addr_t memRdAddr,
	input colourPkg::word_t memRdData,
	output logic uLoad,
	output logic vLoad,
	output logic shift,
	yuvPairIf.src pair
);
	import colourPkg::*;

	localparam int PairsPerRow = ImageWidth / 2;
	localparam int ChromaWords = ImageWidth / 4;
	localparam int PrefetchWords = (ChromaWords < 3) ? ChromaWords : 3;
	localparam int PairW = $clog2(PairsPerRow);
	localparam int WordW = $clog2(ChromaWords + 1);
	localparam int RowW = $clog2(ImageHeight + 1);

	localparam logic [1:0] SIdle = 2'd0;
	localparam logic [1:0] SPrefetch = 2'd1;
	localparam logic [1:0] SPairs = 2'd2;

	localparam logic [1:0] TagNone = 2'd0;
	localparam logic [1:0] TagY = 2'd1;
	localparam logic [1:0] TagU = 2'd2;
	localparam logic [1:0] TagV = 2'd3;

	logic [1:0] state;
	logic [1:0] phase;                 // Cycle within a 4-cycle pair slot
	logic [PairW-1:0] pairCnt;
	logic [RowW-1:0] rowCnt;
	logic [2:0] pfStep;
	logic [WordW-1:0] wordCnt;         // Chroma words read in this row
	addr_t yAddr, uAddr, vAddr;
	logic [1:0] issueTag;
	logic [2:0] issue;
	logic [2:0] tagPipe [MemReadLatency];
	logic [2:0] tagOut;
	logic lastPair;
	logic needWord;

	assign lastPair = pairCnt == PairW'(PairsPerRow - 1);
	// A fresh chroma word on every odd pair until the row runs out
	assign needWord = pairCnt[0] && (wordCnt < WordW'(ChromaWords));

	always_comb begin
		issueTag = TagNone;
		memRdAddr = yAddr;
		if (state == SPrefetch) begin
			if (pfStep[0]) begin
				issueTag = TagV;
				memRdAddr = vAddr;
			end else begin
				issueTag = TagU;
				memRdAddr = uAddr;
			end
		end else if (state == SPairs) begin
			case (phase)
				2'd0: issueTag = TagY;
				2'd1: begin
					if (needWord) begin
						issueTag = TagU;
						memRdAddr = uAddr;
					end
				end
				2'd2: begin
					if (needWord) begin
						issueTag = TagV;
						memRdAddr = vAddr;
					end
				end
				default: issueTag = TagNone;
			endcase
		end
	end

	assign memRdEn = issueTag != TagNone;
	assign issue = {lastPair, issueTag};

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= SIdle;
			phase <= 2'd0;
			pairCnt <= '0;
			rowCnt <= '0;
			pfStep <= 3'd0;
			wordCnt <= '0;
			yAddr <= '0;
			uAddr <= '0;
			vAddr <= '0;
		end else begin
			if (issueTag == TagY)
				yAddr <= yAddr + 1'b1;
			if (issueTag == TagU)
				uAddr <= uAddr + 1'b1;
			if (issueTag == TagV) begin
				vAddr <= vAddr + 1'b1;
				wordCnt <= wordCnt + 1'b1;
			end
			case (state)
				SIdle: begin
					if (start) begin
						state <= SPrefetch;
						yAddr <= '0;
						uAddr <= addr_t'(UBase);
						vAddr <= addr_t'(VBase);
						rowCnt <= '0;
						pfStep <= 3'd0;
						wordCnt <= '0;
					end
				end
				SPrefetch: begin
					pfStep <= pfStep + 3'd1;
					if (pfStep == 3'(2 * PrefetchWords - 1)) begin
						state <= SPairs;
						phase <= 2'd0;
						pairCnt <= '0;
					end
				end
				SPairs: begin
					phase <= phase + 2'd1;
					if (phase == 2'd3) begin
						pairCnt <= pairCnt + 1'b1;
						if (lastPair) begin
							pairCnt <= '0;
							pfStep <= 3'd0;
							wordCnt <= '0;
							rowCnt <= rowCnt + 1'b1;
							state <= (rowCnt == RowW'(ImageHeight - 1)) ? SIdle : SPrefetch;
						end
					end
				end
				default: state <= SIdle;
			endcase
		end
	end

	// Tag travels alongside each read so the returning word can be routed
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < MemReadLatency; i++)
				tagPipe[i] <= {1'b0, TagNone};
		end else begin
			tagPipe[0] <= issue;
			for (int i = 1; i < MemReadLatency; i++)
				tagPipe[i] <= tagPipe[i-1];
		end
	end

	assign tagOut = tagPipe[MemReadLatency-1];
	assign shift = tagOut[1:0] == TagY;
	assign uLoad = tagOut[1:0] == TagU;
	assign vLoad = tagOut[1:0] == TagV;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			pair.valid <= 1'b0;
			pair.rowLast <= 1'b0;
		end else begin
			pair.valid <= shift;
			pair.rowLast <= shift & tagOut[2];
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (shift)
			pair.y <= {memRdData[7:0], memRdData[15:8]};   // Even pixel in high byte
	end

endmodule

`default_nettype wire

// File: apbRegs.sv
// APB slave holding the start control, busy/done status and completed-row count
`timescale 1ns/1ps
`default_nettype none

module apbRegs (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic [3:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	input logic frameDone,
	input logic rowDone,
	output logic busy
);
	import colourPkg::*;

	logic done;
	logic [15:0] rowCnt;
	logic access;
	logic mapped;

	assign access = psel & penable;   // Access phase
	assign mapped = paddr inside {RegCtrl, RegStatus, RegRows};
	assign pready = 1'b1;
	assign pslverr = access & ~mapped;

	// Start only taken while idle, otherwise the write is dropped
	assign start = access & pwrite & (paddr == RegCtrl) & pwdata[0] & ~busy;

	always_comb begin
		case (paddr)
			RegStatus: prdata = {30'd0, done, busy};
			RegRows: prdata = {16'd0, rowCnt};
			default: prdata = 32'd0;
		endcase
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			busy <= 1'b0;
			done <= 1'b0;
			rowCnt <= 16'd0;
		end else if (start) begin
			busy <= 1'b1;
			done <= 1'b0;
			rowCnt <= 16'd0;
		end else begin
			if (rowDone)
				rowCnt <= rowCnt + 16'd1;
			if (frameDone) begin
				busy <= 1'b0;
				done <= 1'b1;     // Sticky until the next start
			end
		end
	end

endmodule

`default_nettype wire

// File: rgbPairIf.sv
// One converted RGB pixel pair, passed from the converter to the memory writer
`timescale 1ns/1ps
`default_nettype none

interface rgbPairIf;
	import colourPkg::*;

	logic valid;
	logic rowLast;
	sample_t [1:0] r;         // Index 0 is the even pixel
	sample_t [1:0] g;
	sample_t [1:0] b;

	modport src (output valid, rowLast, r, g, b);
	modport dst (input valid, rowLast, r, g, b);

endinterface

`default_nettype wire

// File: yuvPairIf.sv
// One pixel pair of luma and upsampled chroma, passed from the sequencer to the converter
`timescale 1ns/1ps
`default_nettype none

interface yuvPairIf;
	import colourPkg::*;

	logic valid;              // Single-cycle pulse, no ready
	logic rowLast;            // Final pair of a row
	sample_t [1:0] y;         // y[0] is the even pixel
	sample_t uEven, uOdd;     // Driven by the U upsampler
	sample_t vEven, vOdd;     // Driven by the V upsampler

	modport src (output valid, rowLast, y);
	modport dst (input valid, rowLast, y, uEven, uOdd, vEven, vOdd);

endinterface

`default_nettype wire

// File: colourPkg.sv
// Shared widths, coefficients, register map and clipping helper for the colour-conversion core
`default_nettype none

package colourPkg;

	localparam int AddrWidth = 18;
	localparam int DataWidth = 16;
	localparam int MemReadLatency = 2;     // Request to data, in cycles

	typedef logic [7:0] sample_t;
	typedef logic [AddrWidth-1:0] addr_t;
	typedef logic [DataWidth-1:0] word_t;

	// Six-tap interpolation filter
	localparam logic [8:0] CoefNear = 9'd159;
	localparam logic [8:0] CoefMid = 9'd52;
	localparam logic [8:0] CoefFar = 9'd21;

	// Colour-space matrix, 16 fractional bits
	localparam logic [17:0] CscY = 18'd76284;
	localparam logic [17:0] CscRv = 18'd104595;
	localparam logic [17:0] CscGu = 18'd25624;
	localparam logic [17:0] CscGv = 18'd53281;
	localparam logic [17:0] CscBu = 18'd132251;

	localparam sample_t LumaOffset = 8'd16;
	localparam sample_t ChromaOffset = 8'd128;

	// APB register offsets
	localparam logic [3:0] RegCtrl = 4'h0;
	localparam logic [3:0] RegStatus = 4'h4;
	localparam logic [3:0] RegRows = 4'h8;

	// Saturate a signed intermediate to one pixel component
	function automatic sample_t clipSample(input logic signed [31:0] value);
		if (value < 0)
			return 8'd0;
		else if (value > 255)
			return 8'd255;
		return value[7:0];
	endfunction

endpackage

`default_nettype wire
